// ==== logic/ualink_stream_pkg.sv ====
package ualink_stream_pkg;

   // width of the 64-bit command stream
   parameter int DATA_WIDTH = 64;

   // sideband carried alongside every word
   parameter int USER_WIDTH = 32;

   // packet FIFO sizing
   parameter int FIFO_DEPTH_BITS = 4;      // 16 entries

   // entries kept free once nearly-full is raised
   // covers a word already in flight when tready drops
   parameter int NEARLY_FULL_MARGIN = 2;

endpackage

// ==== logic/ualink_cmd_pkg.sv ====
package ualink_cmd_pkg;

   // command opcodes in bits 15:8 of a word
   typedef enum logic [7:0] {
      OP_READ  = 8'hEE,
      OP_WRITE = 8'hEF
   } opcode_e;

   // class given to a word at stream entry
   typedef enum logic [1:0] {
      CLS_PASS  = 2'd0,
      CLS_WRITE = 2'd1,
      CLS_READ  = 2'd2
   } cmd_class_e;

   // field positions inside the data word
   parameter int OPCODE_LSB      = 8;
   parameter int ADDR_LSB        = 16;
   parameter int ADDR_FIELD_BITS = 8;

   // register memory behind the engine
   parameter int MEM_ADDR_WIDTH = 4;       // 16 entries, address taken modulo

   // engine FSM
   typedef enum logic [1:0] {
      ST_FORWARD = 2'd0,                   // mirror the FIFO head
      ST_RESPOND = 2'd1                    // present the read response word
   } engine_state_e;

endpackage

// ==== logic/flit_if.sv ====
`timescale 1ns/1ps

// one stream word plus its decode results, valid/ready handshake
interface flit_if #(
   parameter int data_width = ualink_stream_pkg::DATA_WIDTH,
   parameter int user_width = ualink_stream_pkg::USER_WIDTH
);
   import ualink_cmd_pkg::*;

   logic [data_width-1:0]      data;
   logic [data_width/8-1:0]    strb;
   logic [user_width-1:0]      user;
   logic                       last;
   cmd_class_e                 cls;    // decoded once at entry
   logic [ADDR_FIELD_BITS-1:0] addr;   // raw address field
   logic                       valid;
   logic                       ready;

   // payload side
   modport src (
      output data, strb, user, last, cls, addr, valid,
      input  ready
   );

   // consuming side
   modport snk (
      input  data, strb, user, last, cls, addr, valid,
      output ready
   );

endinterface

// ==== logic/ualink_cmd_parser.sv ====
`timescale 1ns/1ps

module ualink_cmd_parser #(
   parameter int data_width = ualink_stream_pkg::DATA_WIDTH,
   parameter int user_width = ualink_stream_pkg::USER_WIDTH
) (
   input  logic [data_width-1:0]   s_tdata,
   input  logic [data_width/8-1:0] s_tstrb,
   input  logic [user_width-1:0]   s_tuser,
   input  logic                    s_tvalid,
   output logic                    s_tready,
   input  logic                    s_tlast,
   flit_if.src                     in_flit
);
   import ualink_cmd_pkg::*;

   opcode_e opcode;

   // opcode byte, may hold values outside the enum
   assign opcode = opcode_e'(s_tdata[OPCODE_LSB +: $bits(opcode_e)]);

   // classify the word so the engine never looks at the opcode again
   always_comb begin
      case (opcode)
         OP_WRITE: in_flit.cls = CLS_WRITE;
         OP_READ:  in_flit.cls = CLS_READ;
         default:  in_flit.cls = CLS_PASS;
      endcase
   end

   assign in_flit.addr = s_tdata[ADDR_LSB +: ADDR_FIELD_BITS];

   // stream word goes across unchanged
   assign in_flit.data  = s_tdata;
   assign in_flit.strb  = s_tstrb;
   assign in_flit.user  = s_tuser;
   assign in_flit.last  = s_tlast;

   // handshake is shared with the FIFO write side
   assign in_flit.valid = s_tvalid;
   assign s_tready      = in_flit.ready;

endmodule

// ==== logic/pkt_fifo.sv ====
`timescale 1ns/1ps

module pkt_fifo #(
   parameter int data_width      = ualink_stream_pkg::DATA_WIDTH,
   parameter int user_width      = ualink_stream_pkg::USER_WIDTH,
   parameter int fifo_depth_bits = ualink_stream_pkg::FIFO_DEPTH_BITS
) (
   input  logic axi_aclk,
   input  logic axi_resetn,
   flit_if.snk  in_flit,
   flit_if.src  out_flit
);
   import ualink_stream_pkg::*;
   import ualink_cmd_pkg::*;

   localparam int depth = 1 << fifo_depth_bits;

   // one storage array per flit field
   logic [data_width-1:0]      data_mem [depth];
   logic [data_width/8-1:0]    strb_mem [depth];
   logic [user_width-1:0]      user_mem [depth];
   logic                       last_mem [depth];
   cmd_class_e                 cls_mem  [depth];
   logic [ADDR_FIELD_BITS-1:0] addr_mem [depth];

   logic [fifo_depth_bits-1:0] wr_ptr;
   logic [fifo_depth_bits-1:0] rd_ptr;
   logic [fifo_depth_bits:0]   count;
   logic [fifo_depth_bits:0]   free_cnt;
   logic                       wr_en;
   logic                       rd_en;

   assign free_cnt = (fifo_depth_bits + 1)'(depth) - count;

   // nearly-full keeps a margin of free slots
   assign in_flit.ready = (free_cnt >= NEARLY_FULL_MARGIN);
   assign wr_en         = in_flit.valid & in_flit.ready;
   assign rd_en         = out_flit.valid & out_flit.ready;

   always_ff @(posedge axi_aclk) begin
      if (wr_en) begin
         data_mem[wr_ptr] <= in_flit.data;
         strb_mem[wr_ptr] <= in_flit.strb;
         user_mem[wr_ptr] <= in_flit.user;
         last_mem[wr_ptr] <= in_flit.last;
         cls_mem[wr_ptr]  <= in_flit.cls;
         addr_mem[wr_ptr] <= in_flit.addr;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;   // wraps at power-of-two depth
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // fall-through head
   assign out_flit.valid = (count != '0);
   assign out_flit.data  = data_mem[rd_ptr];
   assign out_flit.strb  = strb_mem[rd_ptr];
   assign out_flit.user  = user_mem[rd_ptr];
   assign out_flit.last  = last_mem[rd_ptr];
   assign out_flit.cls   = cls_mem[rd_ptr];
   assign out_flit.addr  = addr_mem[rd_ptr];

   // equal pointers on a non-empty buffer mean every slot is taken
   a_no_write_full: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      wr_en |-> ((wr_ptr != rd_ptr) || (count == '0)));

   // pointers and count must agree on a non-empty buffer
   a_no_read_empty: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      rd_en |-> ((wr_ptr != rd_ptr) || (count == (fifo_depth_bits + 1)'(depth))));

endmodule

// ==== logic/ualink_cmd_engine.sv ====
`timescale 1ns/1ps

module ualink_cmd_engine #(
   parameter int data_width     = ualink_stream_pkg::DATA_WIDTH,
   parameter int user_width     = ualink_stream_pkg::USER_WIDTH,
   parameter int mem_addr_width = ualink_cmd_pkg::MEM_ADDR_WIDTH
) (
   input  logic                    axi_aclk,
   input  logic                    axi_resetn,
   flit_if.snk                     out_flit,
   output logic [data_width-1:0]   m_tdata,
   output logic [data_width/8-1:0] m_tstrb,
   output logic [user_width-1:0]   m_tuser,
   output logic                    m_tvalid,
   input  logic                    m_tready,
   output logic                    m_tlast
);
   import ualink_cmd_pkg::*;

   localparam int mem_depth = 1 << mem_addr_width;

   engine_state_e state;

   // register memory cleared by reset
   logic [data_width-1:0]     mem [mem_depth];
   logic [mem_addr_width-1:0] head_addr;

   // latched from the read command
   logic [mem_addr_width-1:0] rsp_addr;
   logic [user_width-1:0]     rsp_user;
   logic                      rsp_last;

   logic pop;
   logic wr_cmd;
   logic rd_cmd;

   // low address bits wrap the address modulo depth
   assign head_addr = out_flit.addr[mem_addr_width-1:0];

   // FIFO pops only on an m_axis handshake in forward state
   assign out_flit.ready = m_tready && (state == ST_FORWARD);
   assign pop            = out_flit.valid && out_flit.ready;
   assign wr_cmd         = pop && (out_flit.cls == CLS_WRITE);
   assign rd_cmd         = pop && (out_flit.cls == CLS_READ);

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         for (int i = 0; i < mem_depth; i++) begin
            mem[i] <= '0;
         end
      end else if (wr_cmd) begin
         mem[head_addr] <= out_flit.data;   // whole word stored
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (rd_cmd) begin
         rsp_addr <= head_addr;
         rsp_user <= out_flit.user;
         rsp_last <= out_flit.last;   // packet end moves to the response
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state <= ST_FORWARD;
      end else begin
         case (state)
            ST_FORWARD: begin
               if (rd_cmd)
                  state <= ST_RESPOND;
            end
            ST_RESPOND: begin
               if (m_tready)
                  state <= ST_FORWARD;   // response accepted
            end
            default: state <= ST_FORWARD;
         endcase
      end
   end

   // master stream mux
   always_comb begin
      if (state == ST_RESPOND) begin
         m_tdata  = mem[rsp_addr];
         m_tstrb  = '1;
         m_tuser  = rsp_user;
         m_tlast  = rsp_last;
         m_tvalid = 1'b1;
      end else begin
         m_tdata  = out_flit.data;
         m_tstrb  = out_flit.strb;
         m_tuser  = out_flit.user;
         // a read command never closes the packet
         m_tlast  = out_flit.last && (out_flit.cls != CLS_READ);
         m_tvalid = out_flit.valid;
      end
   end

   // stalled word held steady across FIFO and engine
   a_stall_stable: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata)));

   // an accepted read is followed by a response carrying its tuser and tlast
   a_rsp_valid: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      rd_cmd |=> (m_tvalid &&
                  (m_tuser == $past(out_flit.user)) &&
                  (m_tlast == $past(out_flit.last))));

endmodule

// ==== logic/ualink_turbo_top.sv ====
`timescale 1ns/1ps

module ualink_turbo_top #(
   parameter int data_width      = ualink_stream_pkg::DATA_WIDTH,
   parameter int user_width      = ualink_stream_pkg::USER_WIDTH,
   parameter int fifo_depth_bits = ualink_stream_pkg::FIFO_DEPTH_BITS,
   parameter int mem_addr_width  = ualink_cmd_pkg::MEM_ADDR_WIDTH
) (
   input  logic                    axi_aclk,
   input  logic                    axi_resetn,

   // master stream
   output logic [data_width-1:0]   m_axis_tdata,
   output logic [data_width/8-1:0] m_axis_tstrb,
   output logic [user_width-1:0]   m_axis_tuser,
   output logic                    m_axis_tvalid,
   input  logic                    m_axis_tready,
   output logic                    m_axis_tlast,

   // slave stream
   input  logic [data_width-1:0]   s_axis_tdata,
   input  logic [data_width/8-1:0] s_axis_tstrb,
   input  logic [user_width-1:0]   s_axis_tuser,
   input  logic                    s_axis_tvalid,
   output logic                    s_axis_tready,
   input  logic                    s_axis_tlast
);

   // parser to FIFO, FIFO to engine
   flit_if #(.data_width(data_width), .user_width(user_width)) in_flit ();
   flit_if #(.data_width(data_width), .user_width(user_width)) out_flit ();

   ualink_cmd_parser #(
      .data_width (data_width),
      .user_width (user_width)
   ) u_parser (
      .s_tdata  (s_axis_tdata),
      .s_tstrb  (s_axis_tstrb),
      .s_tuser  (s_axis_tuser),
      .s_tvalid (s_axis_tvalid),
      .s_tready (s_axis_tready),
      .s_tlast  (s_axis_tlast),
      .in_flit  (in_flit.src)
   );

   pkt_fifo #(
      .data_width      (data_width),
      .user_width      (user_width),
      .fifo_depth_bits (fifo_depth_bits)
   ) u_fifo (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .in_flit    (in_flit.snk),
      .out_flit   (out_flit.src)
   );

   ualink_cmd_engine #(
      .data_width     (data_width),
      .user_width     (user_width),
      .mem_addr_width (mem_addr_width)
   ) u_engine (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .out_flit   (out_flit.snk),
      .m_tdata    (m_axis_tdata),
      .m_tstrb    (m_axis_tstrb),
      .m_tuser    (m_axis_tuser),
      .m_tvalid   (m_axis_tvalid),
      .m_tready   (m_axis_tready),
      .m_tlast    (m_axis_tlast)
   );

endmodule

// ==== testbench/tb_ualink_turbo.sv ====
`timescale 1ns/1ps

module tb_ualink_turbo;

   // opcodes and limits as the command format defines them
   localparam logic [7:0] opc_write = 8'hEF;
   localparam logic [7:0] opc_read  = 8'hEE;
   localparam int timeout_cycles    = 500;
   localparam int drain_cycles      = 4000;

   // m_axis_tready modes
   localparam int rdy_on    = 0;
   localparam int rdy_stall = 1;
   localparam int rdy_rand  = 2;

   typedef struct packed {
      logic [63:0] data;
      logic [7:0]  strb;
      logic [31:0] user;
      logic        last;
   } word_t;

   logic        axi_aclk = 1'b0;
   logic        axi_resetn;
   logic [63:0] s_axis_tdata;
   logic [7:0]  s_axis_tstrb;
   logic [31:0] s_axis_tuser;
   logic        s_axis_tvalid;
   logic        s_axis_tready;
   logic        s_axis_tlast;
   logic [63:0] m_axis_tdata;
   logic [7:0]  m_axis_tstrb;
   logic [31:0] m_axis_tuser;
   logic        m_axis_tvalid;
   logic        m_axis_tready;
   logic        m_axis_tlast;

   word_t       pkt[$];       // packet being built
   word_t       exp_q[$];     // words the DUT still owes
   word_t       exp_w;
   logic [63:0] model_mem [16];
   int          ready_mode = rdy_on;
   int          errors = 0;
   int          checks = 0;
   int          n_words;
   int          kind;

   ualink_turbo_top dut (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tstrb  (m_axis_tstrb),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .m_axis_tlast  (m_axis_tlast),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tstrb  (s_axis_tstrb),
      .s_axis_tuser  (s_axis_tuser),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .s_axis_tlast  (s_axis_tlast)
   );

   always #50 axi_aclk = ~axi_aclk;

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic finish_run();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   endtask

   // expected output for one packet against the model memory
   function automatic void model_packet(input word_t words[$]);
      word_t w;
      word_t rsp;
      foreach (words[i]) begin
         w = words[i];
         if (w.data[15:8] == opc_write) begin
            model_mem[w.data[19:16]] = w.data;   // address modulo 16
            exp_q.push_back(w);
         end else if (w.data[15:8] == opc_read) begin
            rsp.data = model_mem[w.data[19:16]];
            rsp.strb = 8'hFF;
            rsp.user = w.user;
            rsp.last = w.last;
            w.last   = 1'b0;        // packet end moves to the response
            exp_q.push_back(w);
            exp_q.push_back(rsp);
         end else begin
            exp_q.push_back(w);
         end
      end
   endfunction

   function automatic word_t pass_word(input logic last);
      word_t w;
      w.data = {$urandom, $urandom};
      if (w.data[15:8] == opc_write || w.data[15:8] == opc_read)
         w.data[15:8] = 8'h00;      // keep it a plain word
      w.strb = 8'($urandom);
      w.user = $urandom;
      w.last = last;
      return w;
   endfunction

   function automatic word_t cmd_word(input logic [7:0] op, input logic [7:0] addr,
                                      input logic last);
      word_t w;
      w.data = {$urandom, $urandom};
      w.data[15:8]  = op;
      w.data[23:16] = addr;
      w.strb = 8'($urandom);
      w.user = $urandom;
      w.last = last;
      return w;
   endfunction

   // s_axis_tready is settled at the falling edge before each handshake
   task automatic send_packet(input word_t words[$], input bit gaps);
      int waited;
      int idle;
      foreach (words[i]) begin
         @(negedge axi_aclk);
         if (gaps) begin
            idle = $urandom % 3;
            s_axis_tvalid = 1'b0;
            repeat (idle) @(negedge axi_aclk);
         end
         s_axis_tdata  = words[i].data;
         s_axis_tstrb  = words[i].strb;
         s_axis_tuser  = words[i].user;
         s_axis_tlast  = words[i].last;
         s_axis_tvalid = 1'b1;
         waited = 0;
         while (!s_axis_tready) begin
            if (waited == timeout_cycles) begin
               errors++;
               $display("timeout: s_axis_tready stayed low for %0d cycles", waited);
               finish_run();
            end
            @(negedge axi_aclk);
            waited++;
         end
         @(posedge axi_aclk);    // word taken here
      end
      @(negedge axi_aclk);
      s_axis_tvalid = 1'b0;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0) begin
         if (waited == drain_cycles) begin
            errors++;
            $display("timeout: %0d expected words never came out", exp_q.size());
            finish_run();
         end
         @(negedge axi_aclk);
         waited++;
      end
      repeat (5) @(negedge axi_aclk);   // room for any extra word to show up
   endtask

   task automatic wait_ready_low();
      int waited;
      waited = 0;
      while (s_axis_tready) begin
         if (waited == timeout_cycles) begin
            errors++;
            $display("timeout: s_axis_tready never dropped while the output was stalled");
            finish_run();
         end
         @(negedge axi_aclk);
         waited++;
      end
   endtask

   task automatic set_ready_mode(input int mode);
      @(posedge axi_aclk);
      ready_mode = mode;
   endtask

   always @(negedge axi_aclk) begin
      case (ready_mode)
         rdy_stall: m_axis_tready = 1'b0;
         rdy_rand:  m_axis_tready = ($urandom % 4) != 0;
         default:   m_axis_tready = 1'b1;
      endcase
   end

   // compares every accepted output word with the reference
   always @(posedge axi_aclk) begin
      if (axi_resetn && m_axis_tvalid && m_axis_tready) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("unexpected extra word on m_axis, data %h", m_axis_tdata);
         end else begin
            exp_w = exp_q.pop_front();
            check("m_axis_tdata", m_axis_tdata, exp_w.data);
            check("m_axis_tstrb", m_axis_tstrb, exp_w.strb);
            check("m_axis_tuser", m_axis_tuser, exp_w.user);
            check("m_axis_tlast", m_axis_tlast, exp_w.last);
         end
      end
   end

   initial begin
      void'($urandom(32'h3982));
      foreach (model_mem[i])
         model_mem[i] = '0;
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tstrb  = '0;
      s_axis_tuser  = '0;
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
      m_axis_tready = 1'b0;
      repeat (3) @(posedge axi_aclk);
      @(negedge axi_aclk);
      axi_resetn = 1'b1;
      @(negedge axi_aclk);
      check("m_axis_tvalid", m_axis_tvalid, 1'b0);
      check("s_axis_tready", s_axis_tready, 1'b1);

      // plain words only
      for (int p = 0; p < 4; p++) begin
         pkt.delete();
         for (int k = 0; k < 3 + p; k++)
            pkt.push_back(pass_word(k == 2 + p));
         model_packet(pkt);
         send_packet(pkt, 1'b0);
      end
      wait_drain();

      // read of an address never written
      pkt.delete();
      pkt.push_back(cmd_word(opc_read, 8'h03, 1'b1));
      model_packet(pkt);
      send_packet(pkt, 1'b0);
      wait_drain();

      // write then read back next to an untouched address
      pkt.delete();
      pkt.push_back(cmd_word(opc_write, 8'h05, 1'b1));
      model_packet(pkt);
      send_packet(pkt, 1'b0);
      pkt.delete();
      pkt.push_back(pass_word(1'b0));
      pkt.push_back(cmd_word(opc_read, 8'h05, 1'b0));
      pkt.push_back(cmd_word(opc_read, 8'h06, 1'b1));
      model_packet(pkt);
      send_packet(pkt, 1'b0);
      pkt.delete();
      pkt.push_back(cmd_word(opc_write, 8'h09, 1'b0));
      pkt.push_back(cmd_word(opc_read, 8'h09, 1'b1));   // same packet
      model_packet(pkt);
      send_packet(pkt, 1'b0);
      wait_drain();

      // address field wraps modulo 16
      pkt.delete();
      pkt.push_back(cmd_word(opc_write, 8'h27, 1'b0));
      pkt.push_back(cmd_word(opc_read, 8'h07, 1'b0));
      pkt.push_back(cmd_word(opc_write, 8'h0A, 1'b0));
      pkt.push_back(cmd_word(opc_read, 8'hFA, 1'b1));
      model_packet(pkt);
      send_packet(pkt, 1'b0);
      wait_drain();

      // stall the output until the input side backs off
      set_ready_mode(rdy_stall);
      pkt.delete();
      for (int k = 0; k < 24; k++)
         pkt.push_back((k % 5 == 4) ? cmd_word(opc_read, 8'(k), k == 23) : pass_word(k == 23));
      model_packet(pkt);
      fork
         send_packet(pkt, 1'b0);
         begin
            wait_ready_low();
            repeat (20) @(negedge axi_aclk);
            check("s_axis_tready", s_axis_tready, 1'b0);
            check("m_axis_tvalid", m_axis_tvalid, 1'b1);
            set_ready_mode(rdy_on);
         end
      join
      wait_drain();

      // long mixed run with random output back-pressure
      set_ready_mode(rdy_rand);
      for (int p = 0; p < 60; p++) begin
         pkt.delete();
         n_words = 1 + $urandom % 6;
         for (int k = 0; k < n_words; k++) begin
            kind = $urandom % 3;
            if (kind == 1)
               pkt.push_back(cmd_word(opc_write, 8'($urandom), k == n_words - 1));
            else if (kind == 2)
               pkt.push_back(cmd_word(opc_read, 8'($urandom), k == n_words - 1));
            else
               pkt.push_back(pass_word(k == n_words - 1));
         end
         model_packet(pkt);
         send_packet(pkt, 1'b1);
      end
      wait_drain();
      set_ready_mode(rdy_on);
      repeat (5) @(negedge axi_aclk);
      check("s_axis_tready", s_axis_tready, 1'b1);
      finish_run();
   end

endmodule

// ==== compile.f ====
logic/ualink_stream_pkg.sv
logic/ualink_cmd_pkg.sv
logic/flit_if.sv
logic/ualink_cmd_parser.sv
logic/pkt_fifo.sv
logic/ualink_cmd_engine.sv
logic/ualink_turbo_top.sv
testbench/tb_ualink_turbo.sv
